// ==== rvIsaPkg.sv ====
package rvIsaPkg;

    // -------------------------------------------------------------------------
    // widths
    // -------------------------------------------------------------------------
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // instruction field positions
    localparam int OPCODE_LSB   = 0;
    localparam int OPCODE_W     = 7;
    localparam int RD_LSB       = 7;
    localparam int FUNCT3_LSB   = 12;
    localparam int FUNCT3_W     = 3;
    localparam int RS1_LSB      = 15;
    localparam int RS2_LSB      = 20;
    localparam int FUNCT7_SUB_BIT = 30;  // picks sub over add in R-type

    // -------------------------------------------------------------------------
    // encodings
    // -------------------------------------------------------------------------
    // major opcodes, RV32I values
    typedef enum logic [OPCODE_W-1:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcodeE;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL
    } aluOpE;

    typedef enum logic [1:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_J
    } immFmtE;

endpackage

// ==== pipePkg.sv ====
package pipePkg;

    localparam int DMEM_WORDS  = 64;
    localparam int DMEM_ADDR_W = $clog2(DMEM_WORDS);

    // writeback sources
    typedef enum logic [1:0] {
        RES_ALU,
        RES_MEM,
        RES_PC4
    } resultSelE;

    // operand sources in execute
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_MEM,
        FWD_WB
    } fwdSelE;

    // -------------------------------------------------------------------------
    // stage payloads
    // -------------------------------------------------------------------------
    typedef struct packed {
        logic              regWrite;   // never set for rd = x0
        logic              memWrite;
        logic              memRead;
        logic              branch;
        logic              jump;
        logic              branchNe;
        logic              aluSrcImm;
        rvIsaPkg::aluOpE   aluOp;
        resultSelE         resultSel;
    } ctrlT;

    typedef struct packed {
        logic                              valid;
        logic [rvIsaPkg::XLEN-1:0]         pc;
        ctrlT                              ctrl;
        logic [rvIsaPkg::REG_ADDR_W-1:0]   rs1;
        logic [rvIsaPkg::REG_ADDR_W-1:0]   rs2;
        logic [rvIsaPkg::REG_ADDR_W-1:0]   rd;
        logic [rvIsaPkg::XLEN-1:0]         rs1Val;
        logic [rvIsaPkg::XLEN-1:0]         rs2Val;
        logic [rvIsaPkg::XLEN-1:0]         imm;
    } deStageT;

    typedef struct packed {
        logic                              valid;
        logic [rvIsaPkg::XLEN-1:0]         pc;
        ctrlT                              ctrl;
        logic [rvIsaPkg::REG_ADDR_W-1:0]   rd;
        logic [rvIsaPkg::XLEN-1:0]         aluRes;     // pc + 4 for jal
        logic [rvIsaPkg::XLEN-1:0]         storeData;
    } emStageT;

endpackage

// ==== bypassIf.sv ====
`timescale 1ns/10ps

interface bypassIf;

    // memory stage result
    logic                              memValid;
    logic [rvIsaPkg::REG_ADDR_W-1:0]   memRd;
    logic [rvIsaPkg::XLEN-1:0]         memData;

    // writeback stage result, also the register file write port
    logic                              wbValid;
    logic [rvIsaPkg::REG_ADDR_W-1:0]   wbRd;
    logic [rvIsaPkg::XLEN-1:0]         wbData;

    modport source (
        output memValid, memRd, memData,
        output wbValid, wbRd, wbData
    );

    modport forward (
        input memValid, memRd, memData,
        input wbValid, wbRd, wbData
    );

    modport regWrite (
        input wbValid, wbRd, wbData
    );

endinterface

// ==== decodeStage.sv ====
`timescale 1ns/10ps

module decodeStage (
    input  logic                         clk,
    input  logic                         rstn_i,
    input  logic                         instrValid_i,
    input  logic [rvIsaPkg::XLEN-1:0]    instr_i,
    input  logic [rvIsaPkg::XLEN-1:0]    pc_i,
    input  logic                         flush_i,
    bypassIf.regWrite                    wb,
    output pipePkg::deStageT             de_o
);

    logic [rvIsaPkg::XLEN-1:0]        regs [32];
    rvIsaPkg::opcodeE                 opcode;
    logic [rvIsaPkg::FUNCT3_W-1:0]    funct3;
    logic [rvIsaPkg::REG_ADDR_W-1:0]  rs1, rs2, rd;
    logic [rvIsaPkg::XLEN-1:0]        rs1Val, rs2Val, imm;
    rvIsaPkg::immFmtE                 immFmt;
    rvIsaPkg::aluOpE                  aluFn;
    logic                             fnKnown;
    logic                             known;
    pipePkg::ctrlT                    ctrl;

    assign opcode = rvIsaPkg::opcodeE'(instr_i[rvIsaPkg::OPCODE_LSB +: rvIsaPkg::OPCODE_W]);
    assign funct3 = instr_i[rvIsaPkg::FUNCT3_LSB +: rvIsaPkg::FUNCT3_W];
    assign rs1    = instr_i[rvIsaPkg::RS1_LSB +: rvIsaPkg::REG_ADDR_W];
    assign rs2    = instr_i[rvIsaPkg::RS2_LSB +: rvIsaPkg::REG_ADDR_W];
    assign rd     = instr_i[rvIsaPkg::RD_LSB +: rvIsaPkg::REG_ADDR_W];

    // -------------------------------------------------------------------------
    // control decode
    // -------------------------------------------------------------------------
    always_comb begin
        aluFn   = rvIsaPkg::ALU_ADD;
        fnKnown = 1'b1;
        case (funct3)
            3'b000:  aluFn = rvIsaPkg::ALU_ADD;
            3'b001:  aluFn = rvIsaPkg::ALU_SLL;
            3'b010:  aluFn = rvIsaPkg::ALU_SLT;
            3'b100:  aluFn = rvIsaPkg::ALU_XOR;
            3'b101:  aluFn = rvIsaPkg::ALU_SRL;
            3'b110:  aluFn = rvIsaPkg::ALU_OR;
            3'b111:  aluFn = rvIsaPkg::ALU_AND;
            default: fnKnown = 1'b0;  // sltu
        endcase
    end

    always_comb begin
        ctrl   = '0;
        immFmt = rvIsaPkg::IMM_I;
        known  = 1'b1;
        case (opcode)
            rvIsaPkg::OPC_OP: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = (funct3 == 3'b000 && instr_i[rvIsaPkg::FUNCT7_SUB_BIT])
                                ? rvIsaPkg::ALU_SUB : aluFn;
                known         = fnKnown;
            end
            rvIsaPkg::OPC_OP_IMM: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = aluFn;
                known          = fnKnown;
            end
            rvIsaPkg::OPC_LOAD: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.resultSel = pipePkg::RES_MEM;
                known          = (funct3 == 3'b010);  // lw only
            end
            rvIsaPkg::OPC_STORE: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                immFmt         = rvIsaPkg::IMM_S;
                known          = (funct3 == 3'b010);  // sw only
            end
            rvIsaPkg::OPC_BRANCH: begin
                ctrl.branch   = 1'b1;
                ctrl.branchNe = funct3[0];
                ctrl.aluOp    = rvIsaPkg::ALU_SUB;    // zero flag compares
                immFmt        = rvIsaPkg::IMM_B;
                known         = (funct3[2:1] == 2'b00);
            end
            rvIsaPkg::OPC_JAL: begin
                ctrl.regWrite  = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.resultSel = pipePkg::RES_PC4;
                immFmt         = rvIsaPkg::IMM_J;
            end
            default: known = 1'b0;
        endcase
        ctrl.regWrite = ctrl.regWrite && (rd != '0);  // x0 writes dropped here
    end

    always_comb begin
        case (immFmt)
            rvIsaPkg::IMM_S: imm = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            rvIsaPkg::IMM_B: imm = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                                    instr_i[30:25], instr_i[11:8], 1'b0};
            rvIsaPkg::IMM_J: imm = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                                    instr_i[20], instr_i[30:21], 1'b0};
            default:         imm = {{20{instr_i[31]}}, instr_i[31:20]};
        endcase
    end

    // -------------------------------------------------------------------------
    // register file, write-first reads
    // -------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.wbValid) begin
            regs[wb.wbRd] <= wb.wbData;
        end
    end

    assign rs1Val = (rs1 == '0) ? '0 :
                    (wb.wbValid && wb.wbRd == rs1) ? wb.wbData : regs[rs1];
    assign rs2Val = (rs2 == '0) ? '0 :
                    (wb.wbValid && wb.wbRd == rs2) ? wb.wbData : regs[rs2];

    // decode/execute register
    always_ff @(posedge clk or negedge rstn_i) begin
        if (!rstn_i) begin
            de_o <= '0;
        end else begin
            de_o.valid  <= instrValid_i && known && !flush_i;
            de_o.pc     <= pc_i;
            de_o.ctrl   <= ctrl;
            de_o.rs1    <= rs1;
            de_o.rs2    <= rs2;
            de_o.rd     <= rd;
            de_o.rs1Val <= rs1Val;
            de_o.rs2Val <= rs2Val;
            de_o.imm    <= imm;
        end
    end

    // x0 holds zero whatever the writeback side presents
    x0StaysZero: assert property (@(posedge clk) disable iff (!rstn_i)
        (wb.wbRd == '0) |=> (regs[0] == '0));

endmodule

// ==== executeStage.sv ====
`timescale 1ns/10ps

module executeStage (
    input  logic                         clk,
    input  logic                         rstn_i,
    input  pipePkg::deStageT             de_i,
    bypassIf.forward                     fwd,
    output logic                         flush_o,
    output logic [rvIsaPkg::XLEN-1:0]    redirectPc_o,
    output pipePkg::emStageT             em_o
);

    pipePkg::fwdSelE              sel1, sel2;
    logic [rvIsaPkg::XLEN-1:0]    srcA, rs2Fwd, srcB;
    logic [rvIsaPkg::XLEN-1:0]    aluRes, pcPlus4;
    logic                         zero;

    // memory stage wins over writeback as the younger value
    function automatic pipePkg::fwdSelE pickFwd(
        input logic [rvIsaPkg::REG_ADDR_W-1:0] rs,
        input logic                            memValid,
        input logic [rvIsaPkg::REG_ADDR_W-1:0] memRd,
        input logic                            wbValid,
        input logic [rvIsaPkg::REG_ADDR_W-1:0] wbRd
    );
        if (memValid && memRd == rs) begin
            return pipePkg::FWD_MEM;
        end else if (wbValid && wbRd == rs) begin
            return pipePkg::FWD_WB;
        end
        return pipePkg::FWD_REG;
    endfunction

    assign sel1 = pickFwd(de_i.rs1, fwd.memValid, fwd.memRd, fwd.wbValid, fwd.wbRd);
    assign sel2 = pickFwd(de_i.rs2, fwd.memValid, fwd.memRd, fwd.wbValid, fwd.wbRd);

    // -------------------------------------------------------------------------
    // operand muxes and ALU
    // -------------------------------------------------------------------------
    always_comb begin
        case (sel1)
            pipePkg::FWD_MEM: srcA = fwd.memData;
            pipePkg::FWD_WB:  srcA = fwd.wbData;
            default:          srcA = de_i.rs1Val;
        endcase
        case (sel2)
            pipePkg::FWD_MEM: rs2Fwd = fwd.memData;
            pipePkg::FWD_WB:  rs2Fwd = fwd.wbData;
            default:          rs2Fwd = de_i.rs2Val;
        endcase
    end

    assign srcB = de_i.ctrl.aluSrcImm ? de_i.imm : rs2Fwd;

    always_comb begin
        case (de_i.ctrl.aluOp)
            rvIsaPkg::ALU_ADD: aluRes = srcA + srcB;
            rvIsaPkg::ALU_SUB: aluRes = srcA - srcB;
            rvIsaPkg::ALU_AND: aluRes = srcA & srcB;
            rvIsaPkg::ALU_OR:  aluRes = srcA | srcB;
            rvIsaPkg::ALU_XOR: aluRes = srcA ^ srcB;
            rvIsaPkg::ALU_SLT: aluRes = ($signed(srcA) < $signed(srcB))
                                        ? {{(rvIsaPkg::XLEN-1){1'b0}}, 1'b1} : '0;
            rvIsaPkg::ALU_SLL: aluRes = srcA << srcB[4:0];
            rvIsaPkg::ALU_SRL: aluRes = srcA >> srcB[4:0];
            default:           aluRes = '0;
        endcase
    end

    // -------------------------------------------------------------------------
    // branch decision and redirect
    // -------------------------------------------------------------------------
    assign zero    = (aluRes == '0);
    assign pcPlus4 = de_i.pc + rvIsaPkg::XLEN'(4);

    assign flush_o = de_i.valid &&
                     (de_i.ctrl.jump || (de_i.ctrl.branch && (zero ^ de_i.ctrl.branchNe)));
    assign redirectPc_o = de_i.pc + de_i.imm;  // same adder for branch and jal

    // execute/memory register
    always_ff @(posedge clk or negedge rstn_i) begin
        if (!rstn_i) begin
            em_o <= '0;
        end else begin
            em_o.valid     <= de_i.valid;
            em_o.pc        <= de_i.pc;
            em_o.ctrl      <= de_i.ctrl;
            em_o.rd        <= de_i.rd;
            em_o.aluRes    <= de_i.ctrl.jump ? pcPlus4 : aluRes;
            em_o.storeData <= rs2Fwd;
        end
    end

    // a redirect squashes the payload behind it
    flushSquashes: assert property (@(posedge clk) disable iff (!rstn_i)
        flush_o |=> !de_i.valid);

endmodule

// ==== resultStage.sv ====
`timescale 1ns/10ps

module resultStage (
    input  logic                               clk,
    input  logic                               rstn_i,
    input  pipePkg::emStageT                   em_i,
    bypassIf.source                            byp,
    output logic                               retValid_o,
    output logic [rvIsaPkg::REG_ADDR_W-1:0]    retRd_o,
    output logic [rvIsaPkg::XLEN-1:0]          retData_o,
    output logic [rvIsaPkg::XLEN-1:0]          retPc_o
);

    logic [rvIsaPkg::XLEN-1:0]          dmem [pipePkg::DMEM_WORDS];
    logic [pipePkg::DMEM_ADDR_W-1:0]    memIdx;
    logic [rvIsaPkg::XLEN-1:0]          rdData, result;
    logic                               wbValid;
    logic [rvIsaPkg::REG_ADDR_W-1:0]    wbRd;
    logic [rvIsaPkg::XLEN-1:0]          wbData, wbPc;

    // -------------------------------------------------------------------------
    // data memory, word addressed
    // -------------------------------------------------------------------------
    assign memIdx = em_i.aluRes[2 +: pipePkg::DMEM_ADDR_W];

    always_ff @(posedge clk) begin
        if (em_i.valid && em_i.ctrl.memWrite) begin
            dmem[memIdx] <= em_i.storeData;
        end
    end

    assign rdData = dmem[memIdx];  // async read
    assign result = (em_i.ctrl.resultSel == pipePkg::RES_MEM) ? rdData : em_i.aluRes;

    // loads are not forwarded from here, their data is not ready yet
    assign byp.memValid = em_i.valid && em_i.ctrl.regWrite && !em_i.ctrl.memRead;
    assign byp.memRd    = em_i.rd;
    assign byp.memData  = em_i.aluRes;

    // -------------------------------------------------------------------------
    // memory/writeback register
    // -------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rstn_i) begin
        if (!rstn_i) begin
            wbValid <= 1'b0;
        end else begin
            wbValid <= em_i.valid && em_i.ctrl.regWrite;
        end
    end

    always_ff @(posedge clk) begin
        wbRd   <= em_i.rd;
        wbData <= result;
        wbPc   <= em_i.pc;
    end

    assign byp.wbValid = wbValid;
    assign byp.wbRd    = wbRd;
    assign byp.wbData  = wbData;

    assign retValid_o = wbValid;
    assign retRd_o    = wbRd;
    assign retData_o  = wbData;
    assign retPc_o    = wbPc;

    // upper address bits are dropped by the index, so catch overruns
    dmemInRange: assert property (@(posedge clk) disable iff (!rstn_i)
        em_i.valid && (em_i.ctrl.memRead || em_i.ctrl.memWrite)
        |-> (em_i.aluRes < rvIsaPkg::XLEN'(pipePkg::DMEM_WORDS * 4)));

endmodule

// ==== lanePipeline.sv ====
`timescale 1ns/10ps

module lanePipeline (
    input  logic                               clk,
    input  logic                               rstn_i,
    input  logic                               instrValid_i,
    input  logic [rvIsaPkg::XLEN-1:0]          instr_i,
    input  logic [rvIsaPkg::XLEN-1:0]          pc_i,
    output logic                               redirectValid_o,
    output logic [rvIsaPkg::XLEN-1:0]          redirectPc_o,
    output logic                               retValid_o,
    output logic [rvIsaPkg::REG_ADDR_W-1:0]    retRd_o,
    output logic [rvIsaPkg::XLEN-1:0]          retData_o,
    output logic [rvIsaPkg::XLEN-1:0]          retPc_o
);

    pipePkg::deStageT    de;
    pipePkg::emStageT    em;
    logic                flush;

    bypassIf byp ();

    decodeStage u_decodeStage (
        .clk          (clk),
        .rstn_i       (rstn_i),
        .instrValid_i (instrValid_i),
        .instr_i      (instr_i),
        .pc_i         (pc_i),
        .flush_i      (flush),
        .wb           (byp.regWrite),
        .de_o         (de)
    );

    executeStage u_executeStage (
        .clk          (clk),
        .rstn_i       (rstn_i),
        .de_i         (de),
        .fwd          (byp.forward),
        .flush_o      (flush),
        .redirectPc_o (redirectPc_o),
        .em_o         (em)
    );

    resultStage u_resultStage (
        .clk        (clk),
        .rstn_i     (rstn_i),
        .em_i       (em),
        .byp        (byp.source),
        .retValid_o (retValid_o),
        .retRd_o    (retRd_o),
        .retData_o  (retData_o),
        .retPc_o    (retPc_o)
    );

    assign redirectValid_o = flush;  // flush doubles as the redirect strobe

endmodule

// ==== tbPrograms.svh ====
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// ---------------------------------------------------------------------------
// instruction encoders, RV32I field layouts
// ---------------------------------------------------------------------------
function automatic logic [31:0] encR(input int op, input logic [4:0] rd,
                                     input logic [4:0] rs1, input logic [4:0] rs2);
    logic [2:0] f3;
    logic [6:0] f7;
    f7 = 7'h00;
    case (op)
        OP_SUB:  begin f3 = 3'b000; f7 = 7'h20; end
        OP_AND:  f3 = 3'b111;
        OP_OR:   f3 = 3'b110;
        OP_XOR:  f3 = 3'b100;
        OP_SLT:  f3 = 3'b010;
        OP_SLL:  f3 = 3'b001;
        OP_SRL:  f3 = 3'b101;
        default: f3 = 3'b000;  // add
    endcase
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] encI(input logic [31:0] imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [6:0] opc);
    return {imm[11:0], rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] encS(input logic [31:0] imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] encB(input logic [31:0] imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic ne);
    return {imm[12], imm[10:5], rs2, rs1, 2'b00, ne, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] encJ(input logic [31:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

// ---------------------------------------------------------------------------
// test programs
// ---------------------------------------------------------------------------
task automatic runAluTest();
    int k;
    testName = "aluResults";
    for (int r = 1; r <= 8; r++) begin
        doAddi(5'(r), 5'd0, 12'($random(seed)));
    end
    for (int i = 0; i < ALU_N; i++) begin
        k = ($random(seed) & 32'hff) % 9;
        if (k == 8) begin
            doAddi(5'(($random(seed) & 32'hff) % 9), 5'(($random(seed) & 32'hff) % 9),
                   12'($random(seed)));
        end else begin
            doAluR(k, 5'(($random(seed) & 32'hff) % 9), 5'(($random(seed) & 32'hff) % 9),
                   5'(($random(seed) & 32'hff) % 9));
        end
        repeat (($random(seed) & 32'hff) % 3) idleSlot();
    end
endtask

task automatic runForwardTest();
    testName = "forwarding";
    doAddi(5'd5, 5'd0, 12'h3a7);
    doAluR(OP_ADD, 5'd6, 5'd5, 5'd5);   // memory distance
    doAluR(OP_ADD, 5'd7, 5'd6, 5'd5);   // memory and writeback
    doAluR(OP_SUB, 5'd8, 5'd7, 5'd6);
    doAluR(OP_XOR, 5'd0, 5'd8, 5'd7);   // x0 write, no retire
    doAluR(OP_ADD, 5'd9, 5'd0, 5'd8);
    doAluR(OP_OR,  5'd10, 5'd9, 5'd0);
endtask

task automatic runMemTest();
    int w;
    testName = "storeLoad";
    for (int i = 0; i < MEM_N; i++) begin
        w = ($random(seed) & 32'hff) % 64;
        doAddi(5'd11, 5'd0, 12'($random(seed)));
        doStore(5'd11, w);               // store data forwarded from memory stage
        idleSlot();
        doLoad(5'd12, w);
        doAluR(OP_ADD, 5'd13, 5'd12, 5'd0);
    end
endtask

task automatic runBranchTest();
    testName = "branches";
    doAddi(5'd13, 5'd0, 12'h055);
    doAddi(5'd14, 5'd0, 12'h0aa);
    doBranch(1'b0, 5'd13, 5'd13, 32'd16);        // beq taken
    doBranch(1'b1, 5'd13, 5'd14, -32'sd12);      // bne taken, backward
    doJal(5'd15, 32'd24);
    testName = "notTaken";
    doBranch(1'b0, 5'd13, 5'd14, 32'd8);
    doAluR(OP_ADD, 5'd16, 5'd15, 5'd13);
    doBranch(1'b1, 5'd13, 5'd13, 32'd8);
    doAluR(OP_XOR, 5'd17, 5'd16, 5'd14);
endtask

`endif

// ==== tbLanePipeline.sv ====
`timescale 1ns/10ps

module tbLanePipeline;

    localparam int OP_ADD = 0;
    localparam int OP_SUB = 1;
    localparam int OP_AND = 2;
    localparam int OP_OR  = 3;
    localparam int OP_XOR = 4;
    localparam int OP_SLT = 5;
    localparam int OP_SLL = 6;
    localparam int OP_SRL = 7;

    localparam int ALU_N = 40;
    localparam int MEM_N = 6;
    // reset, seeding, alu with gaps, forwarding, memory, branches, drain
    localparam int PROG_LEN   = 10 + 8 + ALU_N * 3 + 8 + MEM_N * 6 + 20 + 8;
    localparam int TIME_LIMIT = PROG_LEN + 20;

    typedef struct {
        logic [4:0]  rd;
        logic [31:0] data;
        logic [31:0] pc;
        int          cycle;
    } retT;

    logic        clk;
    logic        rstn_i;
    logic        instrValid_i;
    logic [31:0] instr_i;
    logic [31:0] pc_i;
    logic        redirectValid_o;
    logic [31:0] redirectPc_o;
    logic        retValid_o;
    logic [4:0]  retRd_o;
    logic [31:0] retData_o;
    logic [31:0] retPc_o;

    // reference model state
    logic [31:0] regs [32];
    logic [31:0] memModel [64];
    logic [31:0] pc;
    retT         expQ[$];
    int          cyc;
    int          seed;
    string       testName;

    // head of the expected queue and pending redirect, seen by the assertions
    logic        headAvail;
    logic [4:0]  headRd;
    logic [31:0] headData;
    logic [31:0] headPc;
    int          headCycle;
    logic        redirAvail;
    logic [31:0] redirPc;
    int          redirCycle;

    lanePipeline u_lanePipeline (
        .clk             (clk),
        .rstn_i          (rstn_i),
        .instrValid_i    (instrValid_i),
        .instr_i         (instr_i),
        .pc_i            (pc_i),
        .redirectValid_o (redirectValid_o),
        .redirectPc_o    (redirectPc_o),
        .retValid_o      (retValid_o),
        .retRd_o         (retRd_o),
        .retData_o       (retData_o),
        .retPc_o         (retPc_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic reportFail(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic refreshHead();
        headAvail = (expQ.size() != 0);
        if (headAvail) begin
            headRd    = expQ[0].rd;
            headData  = expQ[0].data;
            headPc    = expQ[0].pc;
            headCycle = expQ[0].cycle;
        end
    endtask

    function automatic logic [31:0] aluRef(input int op, input logic [31:0] a,
                                           input logic [31:0] b);
        case (op)
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_SLL:  return a << b[4:0];
            OP_SRL:  return a >> b[4:0];
            default: return a + b;
        endcase
    endfunction

    // one strobe slot; the model retires rd in 3 cycles, a redirect in 1
    task automatic sendOp(input logic [31:0] ins, input logic wr, input logic [4:0] rd,
                          input logic [31:0] data, input logic redir,
                          input logic [31:0] target);
        retT e;
        @(negedge clk);
        instrValid_i = 1'b1;
        instr_i      = ins;
        pc_i         = pc;
        if (wr && rd != 5'd0) begin
            e.rd    = rd;
            e.data  = data;
            e.pc    = pc;
            e.cycle = cyc + 3;
            expQ.push_back(e);
            regs[rd] = data;
            refreshHead();
        end
        if (redir) begin
            redirAvail = 1'b1;
            redirPc    = target;
            redirCycle = cyc + 1;
        end
        pc = pc + 32'd4;
    endtask

    task automatic idleSlot();
        @(negedge clk);
        instrValid_i = 1'b0;
        instr_i      = $random(seed);
    endtask

    task automatic doAluR(input int op, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [4:0] rs2);
        sendOp(encR(op, rd, rs1, rs2), 1'b1, rd, aluRef(op, regs[rs1], regs[rs2]), 1'b0, 0);
    endtask

    task automatic doAddi(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
        logic [31:0] sx;
        sx = {{20{imm[11]}}, imm};
        sendOp(encI(sx, rs1, 3'b000, rd, 7'b0010011), 1'b1, rd, regs[rs1] + sx, 1'b0, 0);
    endtask

    task automatic doStore(input logic [4:0] rs2, input int w);
        memModel[w] = regs[rs2];
        sendOp(encS(32'(w * 4), rs2, 5'd0), 1'b0, 5'd0, 0, 1'b0, 0);
    endtask

    // keeps the idle slot a consumer of the load needs
    task automatic doLoad(input logic [4:0] rd, input int w);
        sendOp(encI(32'(w * 4), 5'd0, 3'b010, rd, 7'b0000011), 1'b1, rd, memModel[w], 1'b0, 0);
        idleSlot();
    endtask

    task automatic doBranch(input logic ne, input logic [4:0] rs1, input logic [4:0] rs2,
                            input logic [31:0] off);
        logic        taken;
        logic [31:0] target;
        taken  = ne ? (regs[rs1] != regs[rs2]) : (regs[rs1] == regs[rs2]);
        target = pc + off;
        sendOp(encB(off, rs2, rs1, ne), 1'b0, 5'd0, 0, taken, target);
        if (taken) begin
            sendOp(encR(OP_ADD, 5'd20, 5'd1, 5'd1), 1'b0, 5'd0, 0, 1'b0, 0);  // wrong path
            pc = target;
        end
    endtask

    task automatic doJal(input logic [4:0] rd, input logic [31:0] off);
        logic [31:0] target;
        target = pc + off;
        sendOp(encJ(off, rd), 1'b1, rd, pc + 32'd4, 1'b1, target);
        sendOp(encR(OP_ADD, 5'd21, 5'd2, 5'd2), 1'b0, 5'd0, 0, 1'b0, 0);  // wrong path
        pc = target;
    endtask

    `include "tbPrograms.svh"

    // ---------------------------------------------------------------------------
    // cycle count, queue pop and timeout
    // ---------------------------------------------------------------------------
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (headAvail && cyc == headCycle) begin
            void'(expQ.pop_front());
            refreshHead();
        end
        if (redirAvail && cyc == redirCycle) begin
            redirAvail = 1'b0;
        end
        if (cyc > TIME_LIMIT) begin
            reportFail($sformatf("timeout after %0d cycles, pipeline stopped retiring", cyc));
        end
    end

    // ---------------------------------------------------------------------------
    // checks
    // ---------------------------------------------------------------------------
    quietInReset: assert property (@(posedge clk) !rstn_i |-> !retValid_o && !redirectValid_o)
        else reportFail("retire or redirect strobe seen during reset");

    noStrayRetire: assert property (@(posedge clk) disable iff (!rstn_i)
        retValid_o |-> headAvail && cyc == headCycle)
        else reportFail($sformatf("unexpected retirement of x%0d in test %s",
                                  $sampled(retRd_o), testName));

    noMissedRetire: assert property (@(posedge clk) disable iff (!rstn_i)
        headAvail && cyc == headCycle |-> retValid_o)
        else reportFail($sformatf("retirement of x%0d missing in test %s",
                                  $sampled(headRd), testName));

    retRdOk: assert property (@(posedge clk) disable iff (!rstn_i)
        retValid_o && headAvail |-> retRd_o == headRd)
        else reportFail($sformatf("Fail %s: rd expected %0d actual %0d", testName,
                                  $sampled(headRd), $sampled(retRd_o)));

    retDataOk: assert property (@(posedge clk) disable iff (!rstn_i)
        retValid_o && headAvail |-> retData_o == headData)
        else reportFail($sformatf("Fail %s: data expected %h actual %h", testName,
                                  $sampled(headData), $sampled(retData_o)));

    retPcOk: assert property (@(posedge clk) disable iff (!rstn_i)
        retValid_o && headAvail |-> retPc_o == headPc)
        else reportFail($sformatf("Fail %s: pc expected %h actual %h", testName,
                                  $sampled(headPc), $sampled(retPc_o)));

    noStrayRedirect: assert property (@(posedge clk) disable iff (!rstn_i)
        redirectValid_o |-> redirAvail && cyc == redirCycle)
        else reportFail($sformatf("unexpected redirect in test %s", testName));

    noMissedRedirect: assert property (@(posedge clk) disable iff (!rstn_i)
        redirAvail && cyc == redirCycle |-> redirectValid_o)
        else reportFail($sformatf("taken branch gave no redirect in test %s", testName));

    redirPcOk: assert property (@(posedge clk) disable iff (!rstn_i)
        redirectValid_o && redirAvail |-> redirectPc_o == redirPc)
        else reportFail($sformatf("Fail %s: redirect pc expected %h actual %h", testName,
                                  $sampled(redirPc), $sampled(redirectPc_o)));

    // ---------------------------------------------------------------------------
    // main sequence
    // ---------------------------------------------------------------------------
    initial begin
        seed         = 6;
        cyc          = 0;
        rstn_i       = 1'b0;
        instrValid_i = 1'b0;
        instr_i      = '0;
        pc_i         = '0;
        pc           = 32'h100;
        headAvail    = 1'b0;
        redirAvail   = 1'b0;
        testName     = "reset";
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rstn_i = 1'b1;
        repeat (2) idleSlot();  // outputs must stay low after release too

        runAluTest();
        runForwardTest();
        runMemTest();
        runBranchTest();
        repeat (6) idleSlot();

        if (expQ.size() != 0 || redirAvail) begin
            reportFail("run ended with expected retirements or redirects still pending");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

// ==== files.f ====
+incdir+.
rvIsaPkg.sv
pipePkg.sv
bypassIf.sv
decodeStage.sv
executeStage.sv
resultStage.sv
lanePipeline.sv
tbLanePipeline.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tbLanePipeline -f files.f -o simLane

./obj_dir/simLane > sim.log 2>&1 || true
cat sim.log

grep -q "^TB PASSED$" sim.log
